/* hw/g729Pkg.sv */
package g729Pkg;

	//////////////////////////////////////////////////
	// Unit and schedule sizes
	//////////////////////////////////////////////////
	localparam int NUM_UNITS = 22;       // External processing units
	localparam int UNIT_WIDTH = 5;       // Bits of a unit identifier
	localparam int STEP_WIDTH = 6;       // Bits of a step number
	localparam int FRAME_STEPS = 17;     // LPC analysis, steps 0 to 16
	localparam int SUBFRAME_STEPS = 18;  // Per subframe, steps 17 to 34

	//////////////////////////////////////////////////
	// Unit identifiers, bit position in unitStart/unitDone
	//////////////////////////////////////////////////
	localparam logic [UNIT_WIDTH-1:0] UNIT_AUTOCORR = 5'd0;
	localparam logic [UNIT_WIDTH-1:0] UNIT_LAG_WINDOW = 5'd1;
	localparam logic [UNIT_WIDTH-1:0] UNIT_LEVINSON = 5'd2;
	localparam logic [UNIT_WIDTH-1:0] UNIT_AZ_LSP = 5'd3;
	localparam logic [UNIT_WIDTH-1:0] UNIT_QUA_LSP = 5'd4;
	localparam logic [UNIT_WIDTH-1:0] UNIT_INT_LPC = 5'd5;
	localparam logic [UNIT_WIDTH-1:0] UNIT_INT_QLPC = 5'd6;
	localparam logic [UNIT_WIDTH-1:0] UNIT_PERC_VAR = 5'd7;
	localparam logic [UNIT_WIDTH-1:0] UNIT_WEIGHT_AZ = 5'd8;
	localparam logic [UNIT_WIDTH-1:0] UNIT_RESIDU = 5'd9;
	localparam logic [UNIT_WIDTH-1:0] UNIT_SYN_FILT = 5'd10;
	localparam logic [UNIT_WIDTH-1:0] UNIT_PITCH_OL = 5'd11;
	localparam logic [UNIT_WIDTH-1:0] UNIT_PITCH_FR3 = 5'd12;
	localparam logic [UNIT_WIDTH-1:0] UNIT_ENC_LAG3 = 5'd13;
	localparam logic [UNIT_WIDTH-1:0] UNIT_PARITY_PITCH = 5'd14;
	localparam logic [UNIT_WIDTH-1:0] UNIT_PRED_LT3 = 5'd15;
	localparam logic [UNIT_WIDTH-1:0] UNIT_CONVOLVE = 5'd16;
	localparam logic [UNIT_WIDTH-1:0] UNIT_G_PITCH = 5'd17;
	localparam logic [UNIT_WIDTH-1:0] UNIT_TEST_ERR = 5'd18;
	localparam logic [UNIT_WIDTH-1:0] UNIT_ACELP_CODEBOOK = 5'd19;
	localparam logic [UNIT_WIDTH-1:0] UNIT_CORR_XY2 = 5'd20;
	localparam logic [UNIT_WIDTH-1:0] UNIT_QUA_GAIN = 5'd21;

	// Counter width for a modulus of n, never below one bit
	function automatic int counterWidth(input int n);
		int width;
		width = (n > 1) ? $clog2(n) : 1;
		return width;
	endfunction

endpackage

/* hw/frameGate.sv */
`timescale 1ns/1ps

module frameGate
	import g729Pkg::*;
#(
	parameter int SEGMENTS_PER_FRAME = 2
)
(
	input logic clock,
	input logic reset,
	input logic enable,
	input logic segmentDone,
	output logic frameReady
);

	localparam int COUNT_WIDTH = counterWidth(SEGMENTS_PER_FRAME);

	logic [COUNT_WIDTH-1:0] segmentCount;  // Segments of the frame being filled
	logic lastSegment;

	assign lastSegment = segmentCount == COUNT_WIDTH'(SEGMENTS_PER_FRAME - 1);

	//////////////////////////////////////////////////
	// Segment counter
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			segmentCount <= '0;
			frameReady <= 1'b0;
		end
		else
		begin
			frameReady <= 1'b0;
			if (!enable)
				segmentCount <= '0;  // Partial frame is thrown away
			else if (segmentDone)
			begin
				if (lastSegment)
				begin
					segmentCount <= '0;
					frameReady <= 1'b1;  // One pulse per full frame
				end
				else
					segmentCount <= segmentCount + 1'b1;
			end
		end
	end

endmodule

/* hw/frameQueue.sv */
`timescale 1ns/1ps

module frameQueue
	import g729Pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input logic clock,
	input logic reset,
	input logic frameReady,
	input logic frameTake,
	output logic frameAvailable,
	output logic frameOverrun
);

	localparam int COUNT_WIDTH = counterWidth(QUEUE_DEPTH + 1);

	logic [COUNT_WIDTH-1:0] pendingCount;  // Frames waiting for the sequencer
	logic queueFull;

	assign queueFull = pendingCount == COUNT_WIDTH'(QUEUE_DEPTH);
	assign frameAvailable = pendingCount != '0;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pendingCount <= '0;
			frameOverrun <= 1'b0;
		end
		else
		begin
			frameOverrun <= 1'b0;
			case ({frameReady, frameTake})
				2'b10:
				begin
					if (queueFull)
						frameOverrun <= 1'b1;  // Frame is lost
					else
						pendingCount <= pendingCount + 1'b1;
				end
				2'b01:
					pendingCount <= pendingCount - 1'b1;
				default:
					pendingCount <= pendingCount;  // Idle, or push and take cancel
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	countBound: assert property (@(posedge clock) disable iff (reset)
		pendingCount <= COUNT_WIDTH'(QUEUE_DEPTH));

	// Sequencer must only take while a frame is pending
	takeWhenPending: assert property (@(posedge clock) disable iff (reset)
		frameTake |-> pendingCount != '0);

endmodule

/* hw/stepTable.sv */
`timescale 1ns/1ps

module stepTable
	import g729Pkg::*;
(
	input logic [STEP_WIDTH-1:0] stepIndex,
	output logic [UNIT_WIDTH-1:0] stepUnit,
	output logic firstSubframeOnly,
	output logic lastFrameStep,
	output logic lastSubframeStep
);

	localparam logic [STEP_WIDTH-1:0] PARITY_STEP = 6'd27;

	always_comb
	begin
		stepUnit = UNIT_AUTOCORR;
		case (stepIndex)
			//////////////////////////////////////////////////
			// Frame level LPC analysis
			//////////////////////////////////////////////////
			6'd0: stepUnit = UNIT_AUTOCORR;
			6'd1: stepUnit = UNIT_LAG_WINDOW;
			6'd2: stepUnit = UNIT_LEVINSON;
			6'd3: stepUnit = UNIT_AZ_LSP;
			6'd4: stepUnit = UNIT_QUA_LSP;
			6'd5: stepUnit = UNIT_INT_LPC;
			6'd6: stepUnit = UNIT_INT_QLPC;
			6'd7: stepUnit = UNIT_PERC_VAR;
			6'd8: stepUnit = UNIT_WEIGHT_AZ;   // First half of frame
			6'd9: stepUnit = UNIT_WEIGHT_AZ;
			6'd10: stepUnit = UNIT_RESIDU;
			6'd11: stepUnit = UNIT_SYN_FILT;
			6'd12: stepUnit = UNIT_WEIGHT_AZ;  // Second half of frame
			6'd13: stepUnit = UNIT_WEIGHT_AZ;
			6'd14: stepUnit = UNIT_RESIDU;
			6'd15: stepUnit = UNIT_SYN_FILT;
			6'd16: stepUnit = UNIT_PITCH_OL;
			//////////////////////////////////////////////////
			// Subframe loop body
			//////////////////////////////////////////////////
			6'd17: stepUnit = UNIT_WEIGHT_AZ;
			6'd18: stepUnit = UNIT_WEIGHT_AZ;
			6'd19: stepUnit = UNIT_SYN_FILT;   // Impulse response
			6'd20: stepUnit = UNIT_SYN_FILT;
			6'd21: stepUnit = UNIT_RESIDU;     // Target signal
			6'd22: stepUnit = UNIT_SYN_FILT;
			6'd23: stepUnit = UNIT_RESIDU;
			6'd24: stepUnit = UNIT_SYN_FILT;
			6'd25: stepUnit = UNIT_PITCH_FR3;  // Closed loop pitch
			6'd26: stepUnit = UNIT_ENC_LAG3;
			6'd27: stepUnit = UNIT_PARITY_PITCH;
			6'd28: stepUnit = UNIT_PRED_LT3;
			6'd29: stepUnit = UNIT_CONVOLVE;
			6'd30: stepUnit = UNIT_G_PITCH;
			6'd31: stepUnit = UNIT_TEST_ERR;
			6'd32: stepUnit = UNIT_ACELP_CODEBOOK;
			6'd33: stepUnit = UNIT_CORR_XY2;
			6'd34: stepUnit = UNIT_QUA_GAIN;
			default: stepUnit = UNIT_AUTOCORR;  // Never reached in a frame
		endcase

		firstSubframeOnly = stepIndex == PARITY_STEP;  // Parity only on subframe 0
		lastFrameStep = stepIndex == STEP_WIDTH'(FRAME_STEPS - 1);
		lastSubframeStep = stepIndex == STEP_WIDTH'(FRAME_STEPS + SUBFRAME_STEPS - 1);

		unitInRange: assert (int'(stepUnit) < NUM_UNITS);
	end

endmodule

/* hw/encoderSequencer.sv */
`timescale 1ns/1ps

module encoderSequencer
	import g729Pkg::*;
#(
	parameter int SUBFRAMES_PER_FRAME = 2
)
(
	input logic clock,
	input logic reset,
	input logic frameAvailable,
	input logic abort,
	input logic [NUM_UNITS-1:0] unitDone,
	output logic frameTake,
	output logic [NUM_UNITS-1:0] unitStart,
	output logic [STEP_WIDTH-1:0] stepSelect,
	output logic [counterWidth(SUBFRAMES_PER_FRAME)-1:0] subframeIndex,
	output logic frameDone
);

	localparam int SUBFRAME_WIDTH = counterWidth(SUBFRAMES_PER_FRAME);

	localparam logic [1:0] STATE_IDLE = 2'd0;
	localparam logic [1:0] STATE_ISSUE = 2'd1;  // Start pulse cycle
	localparam logic [1:0] STATE_WAIT = 2'd2;   // Waiting on the unit
	localparam logic [1:0] STATE_SKIP = 2'd3;   // Step passed over

	logic [1:0] state;
	logic [STEP_WIDTH-1:0] stepCount;
	logic [STEP_WIDTH-1:0] lookaheadStep;
	logic [SUBFRAME_WIDTH-1:0] subframeCount;
	logic [UNIT_WIDTH-1:0] currentUnit;
	logic currentFirstOnly;
	logic lastFrameStep;
	logic lastSubframeStep;
	logic nextFirstOnly;
	logic lastSubframe;
	logic stepDone;
	logic skipNext;

	stepTable currentTable_i (
		.stepIndex(stepCount),
		.stepUnit(currentUnit),
		.firstSubframeOnly(currentFirstOnly),
		.lastFrameStep(lastFrameStep),
		.lastSubframeStep(lastSubframeStep)
	);

	// Flags of the following step, to decide on a skip at the done pulse
	stepTable lookaheadTable_i (
		.stepIndex(lookaheadStep),
		.stepUnit(),
		.firstSubframeOnly(nextFirstOnly),
		.lastFrameStep(),
		.lastSubframeStep()
	);

	assign lookaheadStep = stepCount + 1'b1;
	assign lastSubframe = subframeCount == SUBFRAME_WIDTH'(SUBFRAMES_PER_FRAME - 1);
	assign stepDone = unitDone[currentUnit];  // Other done bits ignored
	assign skipNext = nextFirstOnly && (subframeCount != '0);

	assign frameTake = (state == STATE_IDLE) && frameAvailable && !abort;
	assign unitStart = (state == STATE_ISSUE) ? (NUM_UNITS'(1) << currentUnit) : '0;
	assign stepSelect = stepCount;
	assign subframeIndex = subframeCount;

	//////////////////////////////////////////////////
	// Step FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= STATE_IDLE;
			stepCount <= '0;
			subframeCount <= '0;
			frameDone <= 1'b0;
		end
		else
		begin
			frameDone <= 1'b0;
			if (abort)
			begin
				state <= STATE_IDLE;  // Frame dropped, queue keeps the rest
				stepCount <= '0;
				subframeCount <= '0;
			end
			else
			begin
				case (state)
					STATE_IDLE:
						if (frameAvailable)
							state <= STATE_ISSUE;  // Step 0 next cycle
					STATE_ISSUE:
						state <= STATE_WAIT;
					STATE_WAIT:
						if (stepDone)
						begin
							if (lastSubframeStep && lastSubframe)
							begin
								state <= STATE_IDLE;
								stepCount <= '0;
								subframeCount <= '0;
								frameDone <= 1'b1;
							end
							else if (lastSubframeStep)
							begin
								state <= STATE_ISSUE;  // Loop back for next subframe
								stepCount <= STEP_WIDTH'(FRAME_STEPS);
								subframeCount <= subframeCount + 1'b1;
							end
							else if (lastFrameStep)
							begin
								state <= STATE_ISSUE;  // Enter subframe loop
								stepCount <= STEP_WIDTH'(FRAME_STEPS);
								subframeCount <= '0;
							end
							else
							begin
								state <= skipNext ? STATE_SKIP : STATE_ISSUE;
								stepCount <= lookaheadStep;
							end
						end
					STATE_SKIP:
					begin
						state <= STATE_ISSUE;
						stepCount <= lookaheadStep;
					end
					default:
						state <= STATE_IDLE;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	startOneHot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(unitStart));

	// Parity pitch is only ever started in the first subframe
	parityFirstOnly: assert property (@(posedge clock) disable iff (reset)
		(state == STATE_ISSUE) && currentFirstOnly |-> subframeCount == '0);

endmodule

/* hw/g729Control.sv */
`timescale 1ns/1ps

module g729Control
	import g729Pkg::*;
#(
	parameter int SEGMENTS_PER_FRAME = 2,
	parameter int QUEUE_DEPTH = 4,
	parameter int SUBFRAMES_PER_FRAME = 2
)
(
	input logic clock,
	input logic reset,
	input logic enable,
	input logic segmentDone,
	input logic [NUM_UNITS-1:0] unitDone,
	input logic abort,
	output logic [NUM_UNITS-1:0] unitStart,
	output logic [STEP_WIDTH-1:0] stepSelect,
	output logic [counterWidth(SUBFRAMES_PER_FRAME)-1:0] subframeIndex,
	output logic frameDone,
	output logic frameOverrun
);

	logic frameReady;      // Gate to queue
	logic frameAvailable;  // Queue to sequencer
	logic frameTake;       // Sequencer back to queue

	frameGate #(
		.SEGMENTS_PER_FRAME(SEGMENTS_PER_FRAME)
	) frameGate_i (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.segmentDone(segmentDone),
		.frameReady(frameReady)
	);

	frameQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) frameQueue_i (
		.clock(clock),
		.reset(reset),
		.frameReady(frameReady),
		.frameTake(frameTake),
		.frameAvailable(frameAvailable),
		.frameOverrun(frameOverrun)
	);

	encoderSequencer #(
		.SUBFRAMES_PER_FRAME(SUBFRAMES_PER_FRAME)
	) encoderSequencer_i (
		.clock(clock),
		.reset(reset),
		.frameAvailable(frameAvailable),
		.abort(abort),
		.unitDone(unitDone),
		.frameTake(frameTake),
		.unitStart(unitStart),
		.stepSelect(stepSelect),
		.subframeIndex(subframeIndex),
		.frameDone(frameDone)
	);

endmodule

/* verif/g729ControlTests.svh */
task automatic singleFrame();
	markLogs();
	sendSegments(SEGMENTS_PER_FRAME);
	waitFrames(1);
	compareCount("singleFrame starts", expectedUnits.size(), seenUnits.size() - startMark);
	matchSchedule("singleFrame", startMark);
	compareCount("singleFrame frameDone", 1, doneCount - doneMark);
	@(negedge clock);
	compareStep("singleFrame idle", '0, stepSelect);  // Zero while idle
endtask

task automatic segmentGating();
	markLogs();
	sendSegments(1);
	@(posedge clock);
	#1 enable = 1'b0;  // Partial frame is cleared
	repeat (50) @(posedge clock);
	compareCount("segmentGating gated", 0, seenUnits.size() - startMark);
	@(posedge clock);
	#1 enable = 1'b1;
	sendSegments(1);
	repeat (20) @(posedge clock);
	compareCount("segmentGating half frame", 0, seenUnits.size() - startMark);
	sendSegments(1);
	waitFrames(1);
	compareCount("segmentGating starts", expectedUnits.size(), seenUnits.size() - startMark);
	matchSchedule("segmentGating", startMark);
	compareCount("segmentGating frameDone", 1, doneCount - doneMark);
endtask

task automatic queuedFrames();
	int frameLength;
	frameLength = expectedUnits.size();
	markLogs();
	sendSegments(SEGMENTS_PER_FRAME);
	while (seenUnits.size() == startMark)
		@(posedge clock);
	sendSegments(2 * SEGMENTS_PER_FRAME);  // Two more behind the running one
	waitFrames(3);
	compareCount("queuedFrames starts", 3 * frameLength, seenUnits.size() - startMark);
	for (int frame = 0; frame < 3; frame++)
		matchSchedule("queuedFrames", startMark + frame * frameLength);
	compareCount("queuedFrames frameDone", 3, doneCount - doneMark);
	compareCount("queuedFrames frameOverrun", 0, overrunCount - overrunMark);
endtask

task automatic overrun();
	int heldFrames;
	heldFrames = QUEUE_DEPTH + 1;  // Queue plus the running frame
	markLogs();
	holdResponder();
	sendSegments(SEGMENTS_PER_FRAME);
	while (seenUnits.size() == startMark)
		@(posedge clock);
	sendSegments((QUEUE_DEPTH + EXCESS_FRAMES) * SEGMENTS_PER_FRAME);
	while (overrunCount - overrunMark < EXCESS_FRAMES)
		@(posedge clock);
	releaseResponder();
	waitFrames(heldFrames);
	compareCount("overrun frameOverrun", EXCESS_FRAMES, overrunCount - overrunMark);
	compareCount("overrun frameDone", heldFrames, doneCount - doneMark);
	@(negedge clock);
	compareCount("overrun starts", heldFrames * expectedUnits.size(),
		seenUnits.size() - startMark);
endtask

task automatic abortFrame();
	int restartMark;
	markLogs();
	sendSegments(2 * SEGMENTS_PER_FRAME);
	while (seenUnits.size() - startMark < ABORT_AFTER_STARTS)
		@(posedge clock);
	@(posedge clock);
	#1 abort = 1'b1;
	@(posedge clock);
	#1 abort = 1'b0;
	restartMark = seenUnits.size();  // Starts of the queued frame follow
	waitFrames(1);
	compareCount("abortFrame frameDone", 1, doneCount - doneMark);
	compareCount("abortFrame starts", expectedUnits.size(), seenUnits.size() - restartMark);
	compareUnit("abortFrame restart", UNIT_AUTOCORR, seenUnits[restartMark]);
	matchSchedule("abortFrame", restartMark);
endtask

/* verif/g729ControlTb.sv */
`timescale 1ns/1ps

module g729ControlTb
	import g729Pkg::*;
();

	localparam int SEGMENTS_PER_FRAME = 2;
	localparam int QUEUE_DEPTH = 4;
	localparam int SUBFRAMES_PER_FRAME = 2;
	localparam int SUBFRAME_WIDTH = counterWidth(SUBFRAMES_PER_FRAME);
	localparam int PARITY_STEP = 27;         // Parity pitch, subframe 0 only
	localparam int EXCESS_FRAMES = 2;        // Frames pushed into a full queue
	localparam int ABORT_AFTER_STARTS = 20;  // Mid-frame point for the abort
	localparam int QUIET_CYCLES = 8;         // Idle time after the last frame of a test
	localparam int TIMEOUT_CYCLES = 4000;    // 12 frames of 53 steps at 5 cycles, plus gaps

	localparam logic [UNIT_WIDTH-1:0] FRAME_UNITS [FRAME_STEPS] = '{
		UNIT_AUTOCORR, UNIT_LAG_WINDOW, UNIT_LEVINSON, UNIT_AZ_LSP, UNIT_QUA_LSP,
		UNIT_INT_LPC, UNIT_INT_QLPC, UNIT_PERC_VAR,
		UNIT_WEIGHT_AZ, UNIT_WEIGHT_AZ, UNIT_RESIDU, UNIT_SYN_FILT,
		UNIT_WEIGHT_AZ, UNIT_WEIGHT_AZ, UNIT_RESIDU, UNIT_SYN_FILT, UNIT_PITCH_OL
	};
	localparam logic [UNIT_WIDTH-1:0] SUBFRAME_UNITS [SUBFRAME_STEPS] = '{
		UNIT_WEIGHT_AZ, UNIT_WEIGHT_AZ, UNIT_SYN_FILT, UNIT_SYN_FILT, UNIT_RESIDU,
		UNIT_SYN_FILT, UNIT_RESIDU, UNIT_SYN_FILT, UNIT_PITCH_FR3, UNIT_ENC_LAG3,
		UNIT_PARITY_PITCH, UNIT_PRED_LT3, UNIT_CONVOLVE, UNIT_G_PITCH, UNIT_TEST_ERR,
		UNIT_ACELP_CODEBOOK, UNIT_CORR_XY2, UNIT_QUA_GAIN
	};

	logic clock = 1'b0;
	logic reset;
	logic enable;
	logic segmentDone;
	logic abort;
	logic [NUM_UNITS-1:0] unitDone;
	logic [NUM_UNITS-1:0] unitStart;
	logic [STEP_WIDTH-1:0] stepSelect;
	logic [SUBFRAME_WIDTH-1:0] subframeIndex;
	logic frameDone;
	logic frameOverrun;

	int seed = 38;
	int cycleCount = 0;
	logic responderHeld;              // Freezes all done pulses
	logic [NUM_UNITS-1:0] heldStart;  // Start bit waiting for its done
	int doneDelay = 0;
	logic [UNIT_WIDTH-1:0] seenUnits[$];
	logic [STEP_WIDTH-1:0] seenSteps[$];
	logic [SUBFRAME_WIDTH-1:0] seenSubframes[$];
	logic [UNIT_WIDTH-1:0] expectedUnits[$];
	logic [STEP_WIDTH-1:0] expectedSteps[$];
	logic [SUBFRAME_WIDTH-1:0] expectedSubframes[$];
	int doneCount = 0;
	int overrunCount = 0;
	int startMark;
	int doneMark;
	int overrunMark;

	always #2 clock = ~clock;

	g729Control #(
		.SEGMENTS_PER_FRAME(SEGMENTS_PER_FRAME),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.SUBFRAMES_PER_FRAME(SUBFRAMES_PER_FRAME)
	) g729Control_i (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.segmentDone(segmentDone),
		.unitDone(unitDone),
		.abort(abort),
		.unitStart(unitStart),
		.stepSelect(stepSelect),
		.subframeIndex(subframeIndex),
		.frameDone(frameDone),
		.frameOverrun(frameOverrun)
	);

	//////////////////////////////////////////////////
	// Failure and compare tasks
	//////////////////////////////////////////////////
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compareUnit(input string testName, input logic [UNIT_WIDTH-1:0] expected,
			input logic [UNIT_WIDTH-1:0] actual);
		if (actual !== expected)
			failRun($sformatf("** Error %s unit: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	task automatic compareStep(input string testName, input logic [STEP_WIDTH-1:0] expected,
			input logic [STEP_WIDTH-1:0] actual);
		if (actual !== expected)
			failRun($sformatf("** Error %s step: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	task automatic compareSubframe(input string testName,
			input logic [SUBFRAME_WIDTH-1:0] expected, input logic [SUBFRAME_WIDTH-1:0] actual);
		if (actual !== expected)
			failRun($sformatf("** Error %s subframe: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	task automatic compareCount(input string testName, input int expected, input int actual);
		if (actual != expected)
			failRun($sformatf("** Error %s count: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	// Bit position of a one-hot start vector
	function automatic logic [UNIT_WIDTH-1:0] unitIndex(input logic [NUM_UNITS-1:0] startBits);
		logic [UNIT_WIDTH-1:0] index;
		index = '0;
		for (int bitPos = 0; bitPos < NUM_UNITS; bitPos++)
			if (startBits[bitPos])
				index = UNIT_WIDTH'(bitPos);
		return index;
	endfunction

	// One frame of the encoder schedule, as starts are expected to appear
	task automatic buildSchedule();
		for (int step = 0; step < FRAME_STEPS; step++)
		begin
			expectedUnits.push_back(FRAME_UNITS[step]);
			expectedSteps.push_back(STEP_WIDTH'(step));
			expectedSubframes.push_back('0);
		end
		for (int subframe = 0; subframe < SUBFRAMES_PER_FRAME; subframe++)
			for (int offset = 0; offset < SUBFRAME_STEPS; offset++)
				if (FRAME_STEPS + offset != PARITY_STEP || subframe == 0)
				begin
					expectedUnits.push_back(SUBFRAME_UNITS[offset]);
					expectedSteps.push_back(STEP_WIDTH'(FRAME_STEPS + offset));
					expectedSubframes.push_back(SUBFRAME_WIDTH'(subframe));
				end
	endtask

	task automatic matchSchedule(input string testName, input int base);
		for (int i = 0; i < expectedUnits.size(); i++)
		begin
			compareUnit(testName, expectedUnits[i], seenUnits[base + i]);
			compareStep(testName, expectedSteps[i], seenSteps[base + i]);
			compareSubframe(testName, expectedSubframes[i], seenSubframes[base + i]);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	task automatic sendSegments(input int count);
		repeat (count)
		begin
			@(posedge clock);
			#1 segmentDone = 1'b1;
			@(posedge clock);
			#1 segmentDone = 1'b0;
		end
	endtask

	task automatic markLogs();
		startMark = seenUnits.size();
		doneMark = doneCount;
		overrunMark = overrunCount;
	endtask

	task automatic waitFrames(input int count);
		while (doneCount - doneMark < count)
			@(posedge clock);
		repeat (QUIET_CYCLES) @(negedge clock);  // Late or repeated pulses land in the logs
	endtask

	task automatic holdResponder();
		@(negedge clock);
		responderHeld = 1'b1;
	endtask

	task automatic releaseResponder();
		@(negedge clock);
		responderHeld = 1'b0;
	endtask

	`include "g729ControlTests.svh"

	//////////////////////////////////////////////////
	// Unit responder and output monitor
	//////////////////////////////////////////////////
	initial
	begin : responder
		unitDone = '0;
		forever
		begin
			@(negedge clock);
			if (unitStart != '0)
			begin
				heldStart = unitStart;
				doneDelay = 1 + int'({$random(seed)} % 32'd4);  // 1 to 4 cycles
			end
			if (abort)
				doneDelay = 0;  // Units drop their work with the frame
			@(posedge clock);
			#1;
			unitDone = '0;
			if (doneDelay > 0 && !responderHeld)
			begin
				doneDelay = doneDelay - 1;
				if (doneDelay == 0)
					unitDone = heldStart;
			end
		end
	end

	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (unitStart != '0)
			begin
				seenUnits.push_back(unitIndex(unitStart));
				seenSteps.push_back(stepSelect);
				seenSubframes.push_back(subframeIndex);
			end
			if (frameDone)
				doneCount = doneCount + 1;
			if (frameOverrun)
				overrunCount = overrunCount + 1;
		end
	end

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
			failRun($sformatf("Timeout: tests still running after %0d cycles", cycleCount));
	end

	initial
	begin
		reset = 1'b1;
		enable = 1'b1;
		segmentDone = 1'b0;
		abort = 1'b0;
		responderHeld = 1'b0;
		buildSchedule();
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
		singleFrame();
		segmentGating();
		queuedFrames();
		overrun();
		abortFrame();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+verif
hw/g729Pkg.sv
hw/frameGate.sv
hw/frameQueue.sv
hw/stepTable.sv
hw/encoderSequencer.sv
hw/g729Control.sv
verif/g729ControlTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the g729Control testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module g729ControlTb -o g729ControlSim

simOutput=$(./obj_dir/g729ControlSim || true)
echo "$simOutput"

if echo "$simOutput" | grep -qF "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi
